//--- Makefile
# Verilator lint and simulation of the group norm engine

TOP := group_norm_2d_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f gnorm.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f gnorm.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/group_norm_2d_properties.sv
// Concurrent assertions on the input fork and output handshake of group_norm_2d
`timescale 1ns/1ns

module group_norm_2d_properties import gnorm_pkg::*; (
    input logic                          clk,
    input logic                          reset,
    input logic                          in_ready,
    input logic [$clog2(FIFO_DEPTH)-1:0] fifo_wr_ptr,
    input logic [ITER_WIDTH-1:0]         mean_iter,
    input out_elem_t                     out_data [TILE_SIZE-1:0],
    input logic                          out_valid,
    input logic                          out_ready
);

    logic [TILE_SIZE*OUT_WIDTH-1:0] out_flat;

    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            out_flat[i*OUT_WIDTH +: OUT_WIDTH] = out_data[i];
        end
    end

    // Output tile is held while the sink stalls
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_flat))
        else $error("out_valid or out_data changed while out_ready was low");

    a_reset_idle: assert property (@(posedge clk) reset && $past(reset) |-> !out_valid)
        else $error("out_valid high during reset");

    // Input FIFO and mean counter move only on a tile taken by the top level
    a_no_accept: assert property (@(posedge clk) disable iff (reset)
        !in_ready |=> $stable(fifo_wr_ptr) && $stable(mean_iter))
        else $error("input tile taken while in_ready was low");

endmodule

bind group_norm_2d group_norm_2d_properties i_properties (
    .clk         (clk),
    .reset       (reset),
    .in_ready    (in_ready),
    .fifo_wr_ptr (i_input_fifo.wr_ptr),
    .mean_iter   (i_mean_acc.iter_count),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
);

//--- bench/group_norm_2d_tb.sv
// Testbench for group_norm_2d with a table of groups, expected outputs and random back-pressure
`timescale 1ns/1ns

module group_norm_2d_tb import gnorm_pkg::*; ();

    localparam int NUM_GROUPS     = 7;
    localparam int GROUP_BITS     = NUM_VALUES * IN_WIDTH;
    localparam int TIMEOUT_CYCLES = 2000;

    logic      clk;
    logic      reset;
    in_elem_t  in_data [TILE_SIZE-1:0];
    logic      in_valid;
    logic      in_ready;
    out_elem_t out_data [TILE_SIZE-1:0];
    logic      out_valid;
    logic      out_ready;

    integer seed;
    int     error_count;
    int     tests_passed;
    int     tests_failed;
    int     in_tiles;

    // Element 0 is the leftmost byte, one tile per underscore group
    logic [GROUP_BITS-1:0] group_in [NUM_GROUPS] = '{
        256'h00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000,
        256'hB7B7B7B7_B7B7B7B7_B7B7B7B7_B7B7B7B7_B7B7B7B7_B7B7B7B7_B7B7B7B7_B7B7B7B7,
        256'h10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0,
        256'h30103010_30103010_30103010_30103010_30103010_30103010_30103010_30103010,
        256'h18E808F8_18E808F8_18E808F8_18E808F8_18E808F8_18E808F8_18E808F8_18E808F8,
        256'h50D030F0_50D030F0_50D030F0_50D030F0_50D030F0_50D030F0_50D030F0_50D030F0,
        256'h00000000_00FF0000_00000000_00000000_00000000_00000000_00000000_00000000
    };

    // Zero variance gives 0xFFFF as the root, so a unit difference saturates
    logic [GROUP_BITS-1:0] group_exp [NUM_GROUPS] = '{
        256'h00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000,
        256'h00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000,
        256'h10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0,
        256'h10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0_10F010F0,
        256'h16E907F8_16E907F8_16E907F8_16E907F8_16E907F8_16E907F8_16E907F8_16E907F8,
        256'h14EB0AF5_14EB0AF5_14EB0AF5_14EB0AF5_14EB0AF5_14EB0AF5_14EB0AF5_14EB0AF5,
        256'h7F7F7F7F_7F007F7F_7F7F7F7F_7F7F7F7F_7F7F7F7F_7F7F7F7F_7F7F7F7F_7F7F7F7F
    };

    group_norm_2d i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Accepted input tiles, updated after the edge so readers see the old count
    always @(posedge clk) begin
        if (reset) begin
            in_tiles <= 0;
        end else if (in_valid && in_ready) begin
            in_tiles <= in_tiles + 1;
        end
    end

    function automatic logic [7:0] elem_at(input logic [GROUP_BITS-1:0] vec, input int idx);
        return vec[GROUP_BITS-1-8*idx -: 8];
    endfunction

    task automatic check_idle();
        int errs;
        errs = 0;
        if (out_valid !== 1'b0) begin
            $display("MISMATCH out_valid: got %h expected 0", out_valid);
            errs++;
        end
        if (in_ready !== 1'b1) begin
            $display("MISMATCH in_ready: got %h expected 1", in_ready);
            errs++;
        end
        $display("reset state: %s", (errs == 0) ? "pass" : "FAIL");
        error_count += errs;
        if (errs == 0) tests_passed++;
        else tests_failed++;
    endtask

    task automatic drive_groups();
        int waited;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int t = 0; t < NUM_ITERS; t++) begin
                for (int j = 0; j < TILE_SIZE; j++) begin
                    in_data[j] <= in_elem_t'(elem_at(group_in[g], t * TILE_SIZE + j));
                end
                in_valid <= 1'b1;
                waited = 0;
                @(posedge clk);
                while (!in_ready) begin
                    waited++;
                    if (waited > TIMEOUT_CYCLES) begin
                        $display("Timeout: input tile %0d of group %0d was never accepted", t, g);
                        error_count++;
                        in_valid <= 1'b0;
                        return;
                    end
                    @(posedge clk);
                end
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_groups();
        int        waited;
        int        group_errors;
        logic      got_tile;
        out_elem_t expected;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            group_errors = 0;
            for (int t = 0; t < NUM_ITERS; t++) begin
                waited = 0;
                got_tile = 1'b0;
                while (!got_tile) begin
                    @(posedge clk);
                    got_tile = out_valid && out_ready;
                    out_ready <= 1'($random(seed));
                    waited++;
                    if (!got_tile && waited > TIMEOUT_CYCLES) begin
                        $display("Timeout: output tile %0d of group %0d never arrived", t, g);
                        error_count++;
                        tests_failed++;
                        return;
                    end
                end
                if (in_tiles < (g + 1) * NUM_ITERS) begin
                    $display("Output of group %0d appeared before its inputs were all sent", g);
                    group_errors++;
                end
                for (int j = 0; j < TILE_SIZE; j++) begin
                    expected = out_elem_t'(elem_at(group_exp[g], t * TILE_SIZE + j));
                    if (out_data[j] !== expected) begin
                        $display("MISMATCH group %0d tile %0d out_data[%0d]: got %h expected %h",
                                 g, t, j, out_data[j], expected);
                        group_errors++;
                    end
                end
            end
            $display("group %0d: %s, %0d errors", g, (group_errors == 0) ? "pass" : "FAIL",
                     group_errors);
            error_count += group_errors;
            if (group_errors == 0) tests_passed++;
            else tests_failed++;
        end
        // Nothing more may come out
        out_ready <= 1'b1;
        for (int c = 0; c < 4 * NUM_ITERS; c++) begin
            @(posedge clk);
            if (out_valid) begin
                $display("An extra output tile appeared after the last expected one");
                error_count++;
                break;
            end
        end
    endtask

    initial begin
        seed         = 72609;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        for (int j = 0; j < TILE_SIZE; j++) begin
            in_data[j] = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_idle();
        fork
            drive_groups();
            check_groups();
        join
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- gnorm.f
+incdir+include
hw/gnorm_pkg.sv
hw/tile_fifo.sv
hw/tile_stat_accumulator.sv
hw/diff_square_stage.sv
hw/inv_sqrt_lut.sv
hw/norm_output_stage.sv
hw/group_norm_2d.sv
bench/group_norm_2d_properties.sv
bench/group_norm_2d_tb.sv

//--- hw/diff_square_stage.sv
// Mean subtraction and squaring stage with separate difference and square outputs
`timescale 1ns/1ns

module diff_square_stage import gnorm_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  in_elem_t     tile_data [TILE_SIZE-1:0],
    input  logic         tile_valid,
    output logic         tile_ready,
    input  in_elem_t     mu_data,
    input  logic         mu_valid,
    output logic         mu_ready,
    output diff_elem_t   diff_data [TILE_SIZE-1:0],
    output logic         diff_valid,
    input  logic         diff_ready,
    output square_elem_t square_data [TILE_SIZE-1:0],
    output logic         square_valid,
    input  logic         square_ready
);

    logic [ITER_WIDTH-1:0] iter_count;
    logic                  last_tile;
    logic                  stage_free;
    logic                  accept;
    diff_elem_t            diff_next [TILE_SIZE-1:0];
    square_elem_t          square_next [TILE_SIZE-1:0];

    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            diff_next[i]   = diff_elem_t'(tile_data[i]) - diff_elem_t'(mu_data);
            square_next[i] = square_elem_t'(SQUARE_WIDTH'(diff_next[i])
                                            * SQUARE_WIDTH'(diff_next[i]));
        end
    end

    // Both branches must have drained before a new tile enters
    assign stage_free = (!diff_valid || diff_ready) && (!square_valid || square_ready);
    assign last_tile  = (iter_count == ITER_WIDTH'(NUM_ITERS - 1));
    assign tile_ready = mu_valid && stage_free;
    // Mean is held until the group's last tile
    assign mu_ready   = tile_valid && stage_free && last_tile;
    assign accept     = tile_valid && tile_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            iter_count   <= '0;
            diff_valid   <= 1'b0;
            square_valid <= 1'b0;
        end else if (accept) begin
            iter_count   <= last_tile ? '0 : iter_count + 1'b1;
            diff_valid   <= 1'b1;
            square_valid <= 1'b1;
        end else begin
            if (diff_ready) begin
                diff_valid <= 1'b0;
            end
            if (square_ready) begin
                square_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            diff_data   <= diff_next;
            square_data <= square_next;
        end
    end

endmodule

//--- hw/gnorm_pkg.sv
// Group norm dimensions, fixed-point widths, element types and derived counts
package gnorm_pkg;

    // Channel and tile geometry
    localparam int TOTAL_DIM0     = 4;
    localparam int TOTAL_DIM1     = 4;
    localparam int COMPUTE_DIM0   = 2;
    localparam int COMPUTE_DIM1   = 2;
    localparam int GROUP_CHANNELS = 2;

    localparam int TILE_SIZE  = COMPUTE_DIM0 * COMPUTE_DIM1;
    localparam int NUM_ITERS  = (TOTAL_DIM0 / COMPUTE_DIM0) * (TOTAL_DIM1 / COMPUTE_DIM1)
                                * GROUP_CHANNELS;
    localparam int NUM_VALUES = TOTAL_DIM0 * TOTAL_DIM1 * GROUP_CHANNELS;
    localparam int ITER_WIDTH = $clog2(NUM_ITERS);

    // Input is signed Q4.4
    localparam int IN_WIDTH      = 8;
    localparam int IN_FRAC_WIDTH = 4;
    typedef logic signed [IN_WIDTH-1:0] in_elem_t;

    // Difference Q5.4 and its square Q10.8
    localparam int DIFF_WIDTH   = IN_WIDTH + 1;
    localparam int SQUARE_WIDTH = 2 * DIFF_WIDTH;
    typedef logic signed [DIFF_WIDTH-1:0] diff_elem_t;
    typedef logic [SQUARE_WIDTH-1:0] square_elem_t;

    // Clamped variance and inverse root, unsigned Q8.8
    localparam int ISQRT_WIDTH      = 16;
    localparam int ISQRT_FRAC_WIDTH = 8;

    // Output is signed Q4.4
    localparam int OUT_WIDTH      = 8;
    localparam int OUT_FRAC_WIDTH = 4;
    typedef logic signed [OUT_WIDTH-1:0] out_elem_t;

    // Room for two full groups
    localparam int FIFO_DEPTH = 2 * NUM_ITERS;

endpackage

//--- hw/group_norm_2d.sv
// Top level of the streaming group norm engine, with stage instances and fork wiring
`timescale 1ns/1ns

module group_norm_2d import gnorm_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  in_elem_t  in_data [TILE_SIZE-1:0],
    input  logic      in_valid,
    output logic      in_ready,
    output out_elem_t out_data [TILE_SIZE-1:0],
    output logic      out_valid,
    input  logic      out_ready
);

    // Input side
    in_elem_t fifo_tile [TILE_SIZE-1:0];
    logic     fifo_in_valid;
    logic     fifo_in_ready;
    logic     fifo_out_valid;
    logic     fifo_out_ready;
    logic     mu_in_valid;
    logic     mu_in_ready;
    in_elem_t mu_data;
    logic     mu_valid;
    logic     mu_ready;

    // Processing part
    diff_elem_t             diff_tile [TILE_SIZE-1:0];
    logic                   diff_valid;
    logic                   diff_ready;
    square_elem_t           square_tile [TILE_SIZE-1:0];
    logic                   square_valid;
    logic                   square_ready;
    diff_elem_t             held_diff [TILE_SIZE-1:0];
    logic                   held_diff_valid;
    logic                   held_diff_ready;
    square_elem_t           var_data;
    logic                   var_valid;
    logic                   var_ready;
    logic [ISQRT_WIDTH-1:0] isqrt_data;
    logic                   isqrt_valid;
    logic                   isqrt_ready;

    // Each tile goes to the FIFO and the mean accumulator in the same cycle
    assign in_ready      = fifo_in_ready && mu_in_ready;
    assign fifo_in_valid = in_valid && mu_in_ready;
    assign mu_in_valid   = in_valid && fifo_in_ready;

    tile_fifo #(
        .elem_t (in_elem_t),
        .DEPTH  (FIFO_DEPTH)
    ) i_input_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (fifo_tile),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    tile_stat_accumulator #(
        .elem_t   (in_elem_t),
        .result_t (in_elem_t)
    ) i_mean_acc (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (mu_in_valid),
        .in_ready   (mu_in_ready),
        .stat_data  (mu_data),
        .stat_valid (mu_valid),
        .stat_ready (mu_ready)
    );

    diff_square_stage i_diff_square (
        .clk          (clk),
        .reset        (reset),
        .tile_data    (fifo_tile),
        .tile_valid   (fifo_out_valid),
        .tile_ready   (fifo_out_ready),
        .mu_data      (mu_data),
        .mu_valid     (mu_valid),
        .mu_ready     (mu_ready),
        .diff_data    (diff_tile),
        .diff_valid   (diff_valid),
        .diff_ready   (diff_ready),
        .square_data  (square_tile),
        .square_valid (square_valid),
        .square_ready (square_ready)
    );

    // Differences wait here until the group's inverse root is known
    tile_fifo #(
        .elem_t (diff_elem_t),
        .DEPTH  (FIFO_DEPTH)
    ) i_diff_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (diff_tile),
        .in_valid  (diff_valid),
        .in_ready  (diff_ready),
        .out_data  (held_diff),
        .out_valid (held_diff_valid),
        .out_ready (held_diff_ready)
    );

    tile_stat_accumulator #(
        .elem_t   (square_elem_t),
        .result_t (square_elem_t)
    ) i_var_acc (
        .clk        (clk),
        .reset      (reset),
        .in_data    (square_tile),
        .in_valid   (square_valid),
        .in_ready   (square_ready),
        .stat_data  (var_data),
        .stat_valid (var_valid),
        .stat_ready (var_ready)
    );

    inv_sqrt_lut i_inv_sqrt (
        .clk         (clk),
        .reset       (reset),
        .var_data    (var_data),
        .var_valid   (var_valid),
        .var_ready   (var_ready),
        .isqrt_data  (isqrt_data),
        .isqrt_valid (isqrt_valid),
        .isqrt_ready (isqrt_ready)
    );

    // Output side
    norm_output_stage i_norm_out (
        .clk         (clk),
        .reset       (reset),
        .diff_data   (held_diff),
        .diff_valid  (held_diff_valid),
        .diff_ready  (held_diff_ready),
        .isqrt_data  (isqrt_data),
        .isqrt_valid (isqrt_valid),
        .isqrt_ready (isqrt_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

//--- hw/inv_sqrt_lut.sv
// Table-based inverse square root of the clamped variance, one register stage
`timescale 1ns/1ns

module inv_sqrt_lut import gnorm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  square_elem_t           var_data,
    input  logic                   var_valid,
    output logic                   var_ready,
    output logic [ISQRT_WIDTH-1:0] isqrt_data,
    output logic                   isqrt_valid,
    input  logic                   isqrt_ready
);

`include "inv_sqrt_table.svh"

    localparam int TABLE_SIZE = $size(INV_SQRT_TABLE);
    localparam int K_WIDTH    = $clog2(TABLE_SIZE);
    // Normalized mantissa keeps two integer bits, range [1.0, 4.0)
    localparam int NORM_FRAC  = ISQRT_WIDTH - 2;
    localparam int NORM_ONE   = 1 << NORM_FRAC;
    // One table step is 3/32 of the mantissa
    localparam int K_STEP     = 3 * NORM_ONE / TABLE_SIZE;
    localparam logic [ISQRT_WIDTH-1:0] ISQRT_MAX = '1;

    logic [ISQRT_WIDTH-1:0] clamped;
    logic [ISQRT_WIDTH-1:0] norm;
    logic [K_WIDTH-1:0]     k;
    logic [ISQRT_WIDTH-1:0] entry;
    logic [ISQRT_WIDTH+3:0] scaled;
    logic [ISQRT_WIDTH-1:0] isqrt_next;
    int                     lead;
    int                     shift;
    int                     e;

    always_comb begin
        clamped = (var_data > SQUARE_WIDTH'(ISQRT_MAX)) ? ISQRT_MAX
                                                        : var_data[ISQRT_WIDTH-1:0];
        lead = 0;
        for (int i = 0; i < ISQRT_WIDTH; i++) begin
            if (clamped[i]) begin
                lead = i;
            end
        end
        // Even shift puts the leading one at bit NORM_FRAC or NORM_FRAC+1
        shift = (NORM_FRAC + 1 - lead) & ~1;
        norm  = clamped << shift;
        k     = K_WIDTH'((norm - NORM_ONE) / K_STEP);
        e     = (NORM_FRAC - ISQRT_FRAC_WIDTH - shift) / 2;
        entry = INV_SQRT_TABLE[k];
        if (e >= 0) begin
            scaled = entry >> e;
        end else begin
            scaled = entry << (-e);
        end
        // Zero variance maps to the largest inverse root
        if (clamped == '0 || scaled > ISQRT_MAX) begin
            isqrt_next = ISQRT_MAX;
        end else begin
            isqrt_next = scaled[ISQRT_WIDTH-1:0];
        end
    end

    assign var_ready = !isqrt_valid || isqrt_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            isqrt_valid <= 1'b0;
        end else if (var_ready) begin
            isqrt_valid <= var_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (var_valid && var_ready) begin
            isqrt_data <= isqrt_next;
        end
    end

endmodule

//--- hw/norm_output_stage.sv
// Scaling of differences by the inverse root with floor and saturation to Q4.4
`timescale 1ns/1ns

module norm_output_stage import gnorm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  diff_elem_t             diff_data [TILE_SIZE-1:0],
    input  logic                   diff_valid,
    output logic                   diff_ready,
    input  logic [ISQRT_WIDTH-1:0] isqrt_data,
    input  logic                   isqrt_valid,
    output logic                   isqrt_ready,
    output out_elem_t              out_data [TILE_SIZE-1:0],
    output logic                   out_valid,
    input  logic                   out_ready
);

    // Product fraction minus output fraction
    localparam int SHIFT   = IN_FRAC_WIDTH + ISQRT_FRAC_WIDTH - OUT_FRAC_WIDTH;
    localparam int OUT_MAX = 2 ** (OUT_WIDTH - 1) - 1;
    localparam int OUT_MIN = -(2 ** (OUT_WIDTH - 1));

    logic [ITER_WIDTH-1:0]                iter_count;
    logic                                 last_tile;
    logic                                 stage_free;
    logic                                 accept;
    logic signed [DIFF_WIDTH+ISQRT_WIDTH:0] scaled [TILE_SIZE-1:0];
    out_elem_t                            result [TILE_SIZE-1:0];

    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            scaled[i] = (diff_data[i] * $signed({1'b0, isqrt_data})) >>> SHIFT;
            if (scaled[i] > OUT_MAX) begin
                result[i] = out_elem_t'(OUT_MAX);
            end else if (scaled[i] < OUT_MIN) begin
                result[i] = out_elem_t'(OUT_MIN);
            end else begin
                result[i] = out_elem_t'(scaled[i]);
            end
        end
    end

    assign stage_free  = !out_valid || out_ready;
    assign last_tile   = (iter_count == ITER_WIDTH'(NUM_ITERS - 1));
    assign diff_ready  = isqrt_valid && stage_free;
    // Inverse root serves the whole group and is released with its last tile
    assign isqrt_ready = diff_valid && stage_free && last_tile;
    assign accept      = diff_valid && diff_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            iter_count <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (stage_free) begin
                out_valid <= diff_valid && isqrt_valid;
            end
            if (accept) begin
                iter_count <= last_tile ? '0 : iter_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= result;
        end
    end

endmodule

//--- hw/tile_fifo.sv
// Synchronous circular FIFO of whole tiles with an occupancy count
`timescale 1ns/1ns

module tile_fifo import gnorm_pkg::*; #(
    parameter type elem_t = in_elem_t,
    parameter int  DEPTH  = FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  reset,
    input  elem_t in_data [TILE_SIZE-1:0],
    input  logic  in_valid,
    output logic  in_ready,
    output elem_t out_data [TILE_SIZE-1:0],
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_WIDTH   = $clog2(DEPTH);
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    elem_t                  mem [DEPTH-1:0][TILE_SIZE-1:0];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_write;
    logic                   do_read;

    // Wraps explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != COUNT_WIDTH'(DEPTH));
    assign out_valid = (count != '0);
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (!do_write && do_read) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

//--- hw/tile_stat_accumulator.sv
// Group accumulator that sums tiles and emits the floored average per group
`timescale 1ns/1ns

module tile_stat_accumulator import gnorm_pkg::*; #(
    parameter type elem_t   = in_elem_t,
    parameter type result_t = in_elem_t
) (
    input  logic    clk,
    input  logic    reset,
    input  elem_t   in_data [TILE_SIZE-1:0],
    input  logic    in_valid,
    output logic    in_ready,
    output result_t stat_data,
    output logic    stat_valid,
    input  logic    stat_ready
);

    // NUM_VALUES is a power of two, so the divide is a shift
    localparam int DIV_SHIFT = $clog2(NUM_VALUES);
    // One spare bit keeps unsigned inputs positive in the signed sum
    localparam int ACC_WIDTH = $bits(elem_t) + DIV_SHIFT + 1;

    logic [ITER_WIDTH-1:0]       iter_count;
    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] tile_sum;
    logic signed [ACC_WIDTH-1:0] acc_next;
    logic                        last_tile;
    logic                        accept;

    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile_sum = tile_sum + $signed(ACC_WIDTH'(in_data[i]));
        end
        acc_next = acc + tile_sum;
    end

    assign last_tile = (iter_count == ITER_WIDTH'(NUM_ITERS - 1));
    // Stall only the tile that would overwrite a result still waiting
    assign in_ready  = !(last_tile && stat_valid && !stat_ready);
    assign accept    = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            iter_count <= '0;
            acc        <= '0;
            stat_valid <= 1'b0;
        end else begin
            if (stat_valid && stat_ready) begin
                stat_valid <= 1'b0;
            end
            if (accept && last_tile) begin
                iter_count <= '0;
                acc        <= '0;
                stat_valid <= 1'b1;
            end else if (accept) begin
                iter_count <= iter_count + 1'b1;
                acc        <= acc_next;
            end
        end
    end

    // Arithmetic shift gives the floor for negative sums
    always_ff @(posedge clk) begin
        if (accept && last_tile) begin
            stat_data <= result_t'(acc_next >>> DIV_SHIFT);
        end
    end

endmodule

//--- include/inv_sqrt_table.svh
// Inverse square root table, 1/sqrt(1 + k*3/32) in unsigned Q8.8 for k = 0 to 31
`ifndef INV_SQRT_TABLE_SVH
`define INV_SQRT_TABLE_SVH

// Mantissas from 1.0 up to just below 4.0
localparam logic [15:0] INV_SQRT_TABLE [32] = '{
    16'd256, 16'd245, 16'd235, 16'd226, 16'd218, 16'd211, 16'd205, 16'd199,
    16'd194, 16'd189, 16'd184, 16'd180, 16'd176, 16'd172, 16'd168, 16'd165,
    16'd162, 16'd159, 16'd156, 16'd154, 16'd151, 16'd149, 16'd146, 16'd144,
    16'd142, 16'd140, 16'd138, 16'd136, 16'd134, 16'd133, 16'd131, 16'd130
};

`endif
